// File: Makefile
# Verilator build and run for the wormhole injection stage

SIM = obj_dir/Vwh_inject_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module wh_inject_tb -f compile.f

# the run passes only when the simulation prints its pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: bench/wh_inject_tb.sv
//////////////////////////////////////////////////////////////
// wormhole injection stage testbench
// random packets on both ports, rebuilt from the link
//////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "wh_defines.svh"

module wh_inject_tb;

  import wh_pkg::*;

  localparam int total_pkts = 400;

  logic       clk_i;
  logic       rst_n_i;
  wh_packet_s pkt_a_i;
  logic       pkt_a_v_i;
  logic       pkt_a_ready_o;
  wh_packet_s pkt_b_i;
  logic       pkt_b_v_i;
  logic       pkt_b_ready_o;
  wh_flit_u   link_data_o;
  logic       link_v_o;
  logic       link_ready_i;

  // expected packets per source, in the order they were accepted
  wh_packet_s exp_q_a[$];
  wh_packet_s exp_q_b[$];

  logic [`WH_PACKET_W-1:0] rx_bits;
  logic [`WH_LEN_W-1:0]    rx_len;
  logic                    rx_src;
  int                      rx_cnt = 0;
  int                      rx_pkts = 0;
  logic                    served = 1'b0;
  logic                    last_src;
  logic                    prev_stall = 1'b0;
  wh_flit_u                prev_data;
  logic                    rand_ready = 1'b0;

  wh_inject_top i_wh_inject_top (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .pkt_a_i       (pkt_a_i),
    .pkt_a_v_i     (pkt_a_v_i),
    .pkt_a_ready_o (pkt_a_ready_o),
    .pkt_b_i       (pkt_b_i),
    .pkt_b_v_i     (pkt_b_v_i),
    .pkt_b_ready_o (pkt_b_ready_o),
    .link_data_o   (link_data_o),
    .link_v_o      (link_v_o),
    .link_ready_i  (link_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_packet(input string name, input wh_packet_s got, input wh_packet_s exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%016h, expected 0x%016h", name, got, exp));
    end
  endtask

  task automatic check_flit(input string name, input wh_flit_u got, input wh_flit_u exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%04h, expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////

  // bit 15 of every flit word carries the source index, so that
  // each flit on the link tells where it came from
  function automatic wh_packet_s make_packet(input logic src, input logic [`WH_LEN_W-1:0] len);
    logic [`WH_PACKET_W-1:0] bits;
    wh_packet_s              pkt;
    bits = {$urandom, $urandom};
    for (int i = 0; i < `WH_MAX_FLITS; i++) begin
      bits[i * `WH_FLIT_W + `WH_FLIT_W - 1] = src;
    end
    pkt = bits;
    pkt.len = len;
    return pkt;
  endfunction

  task automatic drive_source(input logic src, input wh_packet_s pkt, input logic v);
    if (src) begin
      pkt_b_i   = pkt;
      pkt_b_v_i = v;
    end else begin
      pkt_a_i   = pkt;
      pkt_a_v_i = v;
    end
  endtask

  // starts on a rising edge and returns on the edge that takes the packet
  task automatic send_packet(input logic src, input wh_packet_s pkt, input int gap);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    #2;
    drive_source(src, pkt, 1'b0);
    repeat (gap) @(posedge clk_i);
    if (gap > 0) #2;
    drive_source(src, pkt, 1'b1);
    while (!taken) begin
      @(negedge clk_i);
      taken = src ? pkt_b_ready_o : pkt_a_ready_o;
      if (taken) begin
        if (src) exp_q_b.push_back(pkt);
        else exp_q_a.push_back(pkt);
      end else begin
        waited++;
        if (waited > 500) abort_run($sformatf("source %0d never got its packet accepted", src));
      end
      @(posedge clk_i);
    end
  endtask

  task automatic run_source(input logic src, input int n_pkts);
    wh_packet_s pkt;
    int         gap;
    for (int n = 0; n < n_pkts; n++) begin
      pkt = make_packet(src, `WH_LEN_W'($urandom_range(0, 3)));
      gap = ($urandom_range(0, 2) == 0) ? int'($urandom_range(1, 4)) : 0;
      send_packet(src, pkt, gap);
    end
    #2;
    drive_source(src, pkt, 1'b0);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q_a.size() != 0 || exp_q_b.size() != 0 || rx_cnt != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > 4000) abort_run("the link did not deliver the queued packets in time");
    end
  endtask

  initial begin
    link_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #2;
      link_ready_i = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // link monitor and packet model
  //////////////////////////////////////////////////////////////

  task automatic take_flit();
    wh_packet_s              got;
    wh_packet_s              exp;
    logic [`WH_PACKET_W-1:0] exp_bits;
    logic [`WH_PACKET_W-1:0] mask;
    if (rx_cnt == 0) begin
      rx_len  = link_data_o.hdr.len;
      rx_src  = link_data_o.raw[`WH_FLIT_W-1];
      rx_bits = '0;
      if (rx_len > `WH_LEN_W'(3)) abort_run("a header flit carries a length above 3");
    end else begin
      check_bit("link_data_o[15]", link_data_o.raw[`WH_FLIT_W-1], rx_src);
    end
    rx_bits[rx_cnt * `WH_FLIT_W +: `WH_FLIT_W] = link_data_o.raw;
    if (rx_cnt == int'(rx_len)) begin
      last_src = rx_src;
      served   = 1'b1;
      if ((rx_src ? exp_q_b.size() : exp_q_a.size()) == 0) begin
        abort_run($sformatf("a packet from source %0d reached the link unexpectedly", rx_src));
      end
      exp = rx_src ? exp_q_b.pop_front() : exp_q_a.pop_front();
      // flits beyond len never leave the adapter
      mask = {`WH_PACKET_W{1'b1}} >> ((`WH_MAX_FLITS - 1 - int'(rx_len)) * `WH_FLIT_W);
      exp_bits = exp;
      exp = exp_bits & mask;
      got = rx_bits;
      check_packet("link packet", got, exp);
      rx_cnt = 0;
      rx_pkts++;
    end else begin
      rx_cnt++;
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (prev_stall) begin
        check_bit("link_v_o", link_v_o, 1'b1);
        check_flit("link_data_o", link_data_o, prev_data);
      end
      // both adapters hold a header at an open boundary, so the
      // source that did not send the last packet goes first
      if (served && rx_cnt == 0 && !prev_stall && link_v_o &&
          !pkt_a_ready_o && !pkt_b_ready_o) begin
        check_bit("link_data_o[15] after a tie", link_data_o.raw[`WH_FLIT_W-1], ~last_src);
      end
      prev_stall = link_v_o && !link_ready_i;
      prev_data  = link_data_o;
      if (link_v_o && link_ready_i) take_flit();
    end
  end

  //////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(39));
    rst_n_i   = 1'b0;
    pkt_a_i   = '0;
    pkt_a_v_i = 1'b0;
    pkt_b_i   = '0;
    pkt_b_v_i = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      check_bit("link_v_o", link_v_o, 1'b0);
      check_bit("pkt_a_ready_o", pkt_a_ready_o, 1'b1);
      check_bit("pkt_b_ready_o", pkt_b_ready_o, 1'b1);
    end
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_bit("link_v_o", link_v_o, 1'b0);
    check_bit("pkt_a_ready_o", pkt_a_ready_o, 1'b1);
    check_bit("pkt_b_ready_o", pkt_b_ready_o, 1'b1);
    @(posedge clk_i);

    // one packet at a time, every length on both ports
    for (int src = 0; src < 2; src++) begin
      for (int len = 0; len < `WH_MAX_FLITS; len++) begin
        send_packet(src[0], make_packet(src[0], `WH_LEN_W'(len)), 0);
        #2;
        drive_source(src[0], '0, 1'b0);
        wait_drained();
        @(posedge clk_i);
      end
    end

    // both ports busy with a stalling link
    rand_ready = 1'b1;
    fork
      run_source(1'b0, (total_pkts - 8) / 2);
      run_source(1'b1, (total_pkts - 8) / 2);
    join
    wait_drained();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_i);
      check_bit("link_v_o", link_v_o, 1'b0);
    end
    if (rx_pkts != total_pkts) begin
      abort_run($sformatf("only %0d of %0d packets reached the link", rx_pkts, total_pkts));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+hw
hw/wh_pkg.sv
hw/wh_adapter_in.sv
hw/wh_link_arbiter.sv
hw/wh_inject_top.sv
bench/wh_inject_tb.sv

// File: hw/wh_adapter_in.sv
//////////////////////////////////////////////////////////////
// wormhole input adapter
// takes a packet in parallel and sends len+1 flits out,
// lowest flit first
//////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "wh_defines.svh"

module wh_adapter_in (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  wh_pkg::wh_packet_s pkt_i,
  input  logic               pkt_v_i,
  output logic               pkt_ready_o,

  output wh_pkg::wh_flit_u   flit_o,
  output logic               flit_v_o,
  input  logic               flit_ready_i
);

  import wh_pkg::*;

  localparam int idx_w = $clog2(`WH_MAX_FLITS);

  logic [`WH_PACKET_W-1:0]                  pkt_bits;
  logic [`WH_MAX_FLITS-1:0][`WH_FLIT_W-1:0] pkt_words;

  // one held packet, cut into flit words
  wh_flit_u [`WH_MAX_FLITS-1:0] flits_q;

  logic             busy_q;
  logic [idx_w-1:0] idx_q;
  logic [idx_w-1:0] last_q;

  logic pkt_xfer;
  logic flit_xfer;
  logic last_flit;

  //////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////

  assign pkt_ready_o = ~busy_q;
  assign pkt_xfer    = pkt_v_i & pkt_ready_o;

  assign flit_v_o  = busy_q;
  assign flit_xfer = flit_v_o & flit_ready_i;

  // the flit numbered len closes the packet
  assign last_flit = (idx_q == last_q);

  //////////////////////////////////////////////////////////////
  // packet store
  //////////////////////////////////////////////////////////////

  // the packet fills the flit words exactly, cord lands in word 0
  assign pkt_bits  = pkt_i;
  assign pkt_words = pkt_bits;

  always_ff @(posedge clk_i) begin
    if (pkt_xfer) begin
      for (int i = 0; i < `WH_MAX_FLITS; i++) begin
        flits_q[i].raw <= pkt_words[i];
      end
    end
  end

  // current flit stays put until the link side takes it
  assign flit_o = flits_q[idx_q];

  //////////////////////////////////////////////////////////////
  // flit sequencing
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
      last_q <= '0;
    end else if (pkt_xfer) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
      // len counts the flits after the header
      last_q <= pkt_i.len[idx_w-1:0];
    end else if (flit_xfer) begin
      if (last_flit) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/wh_defines.svh
//////////////////////////////////////////////////////////////
// wormhole injection widths
// fixed flit and packet layout shared by the whole stage
//////////////////////////////////////////////////////////////
`ifndef WH_DEFINES_SVH
`define WH_DEFINES_SVH

// one flit on the link
`define WH_FLIT_W 16

// packet fields, least significant first: cord, len, payload
`define WH_CORD_W 4
`define WH_LEN_W 3
`define WH_PAYLOAD_W 57

// full packet and its flit count
`define WH_PACKET_W (`WH_PAYLOAD_W + `WH_LEN_W + `WH_CORD_W)
`define WH_MAX_FLITS 4

// payload bits that ride in the header flit
`define WH_HDR_PAYLOAD_W (`WH_FLIT_W - `WH_LEN_W - `WH_CORD_W)

`endif

// File: hw/wh_inject_top.sv
//////////////////////////////////////////////////////////////
// wormhole injection stage
// two packet adapters sharing one outgoing link
//////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module wh_inject_top (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  wh_pkg::wh_packet_s pkt_a_i,
  input  logic               pkt_a_v_i,
  output logic               pkt_a_ready_o,

  input  wh_pkg::wh_packet_s pkt_b_i,
  input  logic               pkt_b_v_i,
  output logic               pkt_b_ready_o,

  output wh_pkg::wh_flit_u   link_data_o,
  output logic               link_v_o,
  input  logic               link_ready_i
);

  import wh_pkg::*;

  wh_flit_u flit_a;
  logic     flit_a_v;
  logic     flit_a_ready;

  wh_flit_u flit_b;
  logic     flit_b_v;
  logic     flit_b_ready;

  wh_adapter_in i_adapter_a (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pkt_i        (pkt_a_i),
    .pkt_v_i      (pkt_a_v_i),
    .pkt_ready_o  (pkt_a_ready_o),
    .flit_o       (flit_a),
    .flit_v_o     (flit_a_v),
    .flit_ready_i (flit_a_ready)
  );

  wh_adapter_in i_adapter_b (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pkt_i        (pkt_b_i),
    .pkt_v_i      (pkt_b_v_i),
    .pkt_ready_o  (pkt_b_ready_o),
    .flit_o       (flit_b),
    .flit_v_o     (flit_b_v),
    .flit_ready_i (flit_b_ready)
  );

  wh_link_arbiter i_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flit_a_i       (flit_a),
    .flit_a_v_i     (flit_a_v),
    .flit_a_ready_o (flit_a_ready),
    .flit_b_i       (flit_b),
    .flit_b_v_i     (flit_b_v),
    .flit_b_ready_o (flit_b_ready),
    .link_data_o    (link_data_o),
    .link_v_o       (link_v_o),
    .link_ready_i   (link_ready_i)
  );

endmodule

// File: hw/wh_link_arbiter.sv
//////////////////////////////////////////////////////////////
// wormhole link arbiter
// merges two flit streams, one whole packet at a time,
// round-robin at packet boundaries
//////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "wh_defines.svh"

module wh_link_arbiter (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  wh_pkg::wh_flit_u flit_a_i,
  input  logic             flit_a_v_i,
  output logic             flit_a_ready_o,

  input  wh_pkg::wh_flit_u flit_b_i,
  input  logic             flit_b_v_i,
  output logic             flit_b_ready_o,

  output wh_pkg::wh_flit_u link_data_o,
  output logic             link_v_o,
  input  logic             link_ready_i
);

  import wh_pkg::*;

  // locked_q keeps grant_q fixed, body_q says the header is gone
  logic                 locked_q;
  logic                 body_q;
  wh_src_e              grant_q;
  wh_src_e              last_q;
  logic [`WH_LEN_W-1:0] remain_q;

  wh_src_e pick_src;
  wh_src_e cur_src;
  logic    xfer;

  //////////////////////////////////////////////////////////////
  // source selection
  //////////////////////////////////////////////////////////////

  always_comb begin
    if (flit_a_v_i && flit_b_v_i) begin
      pick_src = (last_q == SRC_A) ? SRC_B : SRC_A;
    end else if (flit_b_v_i) begin
      pick_src = SRC_B;
    end else begin
      pick_src = SRC_A;
    end
  end

  assign cur_src = locked_q ? grant_q : pick_src;

  // straight through to the link, no register in the path
  assign link_data_o = (cur_src == SRC_A) ? flit_a_i : flit_b_i;
  assign link_v_o    = (cur_src == SRC_A) ? flit_a_v_i : flit_b_v_i;

  assign flit_a_ready_o = (cur_src == SRC_A) & link_ready_i;
  assign flit_b_ready_o = (cur_src == SRC_B) & link_ready_i;

  assign xfer = link_v_o & link_ready_i;

  //////////////////////////////////////////////////////////////
  // packet lock
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      body_q   <= 1'b0;
      grant_q  <= SRC_A;
      // so that port A wins the first tie
      last_q   <= SRC_B;
      remain_q <= '0;
    end else if (xfer) begin
      if (!body_q) begin
        grant_q <= cur_src;
        if (link_data_o.hdr.len == '0) begin
          // single-flit packet, the boundary comes right back
          locked_q <= 1'b0;
          last_q   <= cur_src;
        end else begin
          locked_q <= 1'b1;
          body_q   <= 1'b1;
          remain_q <= link_data_o.hdr.len;
        end
      end else if (remain_q == `WH_LEN_W'(1)) begin
        locked_q <= 1'b0;
        body_q   <= 1'b0;
        last_q   <= cur_src;
      end else begin
        remain_q <= remain_q - 1'b1;
      end
    end else if (link_v_o && !locked_q) begin
      // a stalled header keeps its source until it is taken
      locked_q <= 1'b1;
      grant_q  <= cur_src;
    end
  end

endmodule

// File: hw/wh_pkg.sv
//////////////////////////////////////////////////////////////
// wormhole injection types
// packet, header flit and flit word views
//////////////////////////////////////////////////////////////
`include "wh_defines.svh"

package wh_pkg;

  // whole packet as handed over by a source
  typedef struct packed {
    logic [`WH_PAYLOAD_W-1:0] payload;
    logic [`WH_LEN_W-1:0]     len;
    logic [`WH_CORD_W-1:0]    cord;
  } wh_packet_s;

  // the first flit carries cord and len in its low bits,
  // with the bottom of the payload above them
  typedef struct packed {
    logic [`WH_HDR_PAYLOAD_W-1:0] payload_lo;
    logic [`WH_LEN_W-1:0]         len;
    logic [`WH_CORD_W-1:0]        cord;
  } wh_hdr_flit_s;

  // a flit is plain data, except at a packet boundary where
  // the arbiter reads it as a header
  typedef union packed {
    logic [`WH_FLIT_W-1:0] raw;
    wh_hdr_flit_s          hdr;
  } wh_flit_u;

  typedef enum logic {
    SRC_A = 1'b0,
    SRC_B = 1'b1
  } wh_src_e;

endpackage
